// File: keypad_pkg.sv
// keypad scanner types: scan and digit vectors, display vectors, scan states, settle time
`default_nettype none

package keypad_pkg;

    // one-hot row or column vector, bit 0 is row 0 / column 0
    typedef logic [3:0] scan_t;

    // hexadecimal key value
    typedef logic [3:0] digit_t;

    // segments, bit 0 is a up to bit 6 is g, active low
    typedef logic [6:0] seg_t;

    // digit enables, active low, bit 0 is the right digit
    typedef logic [1:0] anode_t;

    // scan state machine
    typedef enum logic [1:0] {
        SCAN,
        DEBOUNCE,
        CAPTURE,
        HOLD
    } scan_state_t;

    // cycles a column is driven before the rows are judged
    localparam int SETTLE_CYCLES = 4;

endpackage

`default_nettype wire

// File: keypad_decoder.sv
// keypad decoder: row and column lines to hexadecimal key value
`timescale 1ns/1ns
`default_nettype none

module keypad_decoder import keypad_pkg::*; (
    input  scan_t  row,
    input  scan_t  col,
    output digit_t digit
);

    logic [1:0] row_idx;
    logic [1:0] col_idx;

    // lowest set row bit wins on multiple presses
    always_comb begin
        row_idx = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (row[i]) begin
                row_idx = 2'(i);
            end
        end
    end

    // column is one-hot, so any set bit gives the index
    always_comb begin
        col_idx = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (col[i]) begin
                col_idx = 2'(i);
            end
        end
    end

    // key map, row major
    always_comb begin
        if (row == '0) begin
            digit = '0;
        end else begin
            case ({row_idx, col_idx})
                4'b00_00: digit = 4'h1;
                4'b00_01: digit = 4'h2;
                4'b00_10: digit = 4'h3;
                4'b00_11: digit = 4'hA;
                4'b01_00: digit = 4'h4;
                4'b01_01: digit = 4'h5;
                4'b01_10: digit = 4'h6;
                4'b01_11: digit = 4'hB;
                4'b10_00: digit = 4'h7;
                4'b10_01: digit = 4'h8;
                4'b10_10: digit = 4'h9;
                4'b10_11: digit = 4'hC;
                4'b11_00: digit = 4'hE;
                4'b11_01: digit = 4'h0;
                4'b11_10: digit = 4'hF;
                default:  digit = 4'hD;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: debouncer.sv
// debouncer: counter based filter for one level input
`timescale 1ns/1ns
`default_nettype none

module debouncer #(
    parameter int DEBOUNCE_CYCLES = 500000
) (
    input  logic clk,
    input  logic reset,
    input  logic noisy,
    output logic clean
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [CNT_W-1:0] count;

    // count consecutive samples that disagree with the output
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            clean <= 1'b0;
        end else if (noisy == clean) begin
            // agreement restarts the window
            count <= '0;
        end else if (count == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
            count <= '0;
            clean <= noisy;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: keypad_fsm.sv
// keypad scan FSM: column drive, row synchronizer, press/hold states, key capture
`timescale 1ns/1ns
`default_nettype none

module keypad_fsm import keypad_pkg::*; #(
    parameter int DEBOUNCE_CYCLES = 500000
) (
    input  logic   clk,
    input  logic   reset,
    input  scan_t  row,
    output scan_t  col,
    output digit_t digit,
    output logic   valid_key
);

    localparam int SETTLE_W = $clog2(SETTLE_CYCLES + 1);

    scan_state_t        state;
    scan_state_t        next_state;
    scan_t              row_meta;
    scan_t              row_sync;
    logic [SETTLE_W-1:0] settle_cnt;
    logic               settle_done;
    logic               row_active;
    logic               key_clean;
    digit_t             decoded_digit;

    // two-flop synchronizer on the row inputs
    always_ff @(posedge clk) begin
        if (reset) begin
            row_meta <= '0;
            row_sync <= '0;
        end else begin
            row_meta <= row;
            row_sync <= row_meta;
        end
    end

    assign row_active  = |row_sync;
    assign settle_done = (settle_cnt == SETTLE_W'(SETTLE_CYCLES - 1));

    keypad_decoder u_decoder (
        .row   (row_sync),
        .col   (col),
        .digit (decoded_digit)
    );

    debouncer #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_debouncer (
        .clk   (clk),
        .reset (reset),
        .noisy (row_active),
        .clean (key_clean)
    );

    // settle window, only runs while scanning
    always_ff @(posedge clk) begin
        if (reset) begin
            settle_cnt <= '0;
        end else if (state != SCAN || settle_done) begin
            settle_cnt <= '0;
        end else begin
            settle_cnt <= settle_cnt + 1'b1;
        end
    end

    // rotate the column when the window ends with no row set
    always_ff @(posedge clk) begin
        if (reset) begin
            col <= 4'b0001;
        end else if (state == SCAN && settle_done && !row_active) begin
            col <= {col[2:0], col[3]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= SCAN;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            SCAN: begin
                if (settle_done && row_active) begin
                    next_state = DEBOUNCE;
                end
            end
            DEBOUNCE: begin
                // a release before the filter settles is a bounce
                if (!row_active) begin
                    next_state = SCAN;
                end else if (key_clean) begin
                    next_state = CAPTURE;
                end
            end
            CAPTURE: next_state = HOLD;
            HOLD: begin
                if (!key_clean) begin
                    next_state = SCAN;
                end
            end
            default: next_state = SCAN;
        endcase
    end

    // digit loaded on entry so it is valid during CAPTURE
    always_ff @(posedge clk) begin
        if (next_state == CAPTURE) begin
            digit <= decoded_digit;
        end
    end

    assign valid_key = (state == CAPTURE);

endmodule

`default_nettype wire

// File: sevenseg_decoder.sv
// seven-segment decoder: hexadecimal font, active low, with blanking
`timescale 1ns/1ns
`default_nettype none

module sevenseg_decoder import keypad_pkg::*; (
    input  digit_t value,
    input  logic   blank,
    output seg_t   seg
);

    // patterns are gfedcba, a zero lights the segment
    always_comb begin
        if (blank) begin
            seg = '1;
        end else begin
            case (value)
                4'h0:    seg = 7'b1000000;
                4'h1:    seg = 7'b1111001;
                4'h2:    seg = 7'b0100100;
                4'h3:    seg = 7'b0110000;
                4'h4:    seg = 7'b0011001;
                4'h5:    seg = 7'b0010010;
                4'h6:    seg = 7'b0000010;
                4'h7:    seg = 7'b1111000;
                4'h8:    seg = 7'b0000000;
                4'h9:    seg = 7'b0010000;
                4'hA:    seg = 7'b0001000;
                // lower case b
                4'hB:    seg = 7'b0000011;
                4'hC:    seg = 7'b1000110;
                // lower case d
                4'hD:    seg = 7'b0100001;
                4'hE:    seg = 7'b0000110;
                default: seg = 7'b0001110;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: display_mux.sv
// display mux: two-key history, refresh timer, anode select
`timescale 1ns/1ns
`default_nettype none

module display_mux import keypad_pkg::*; #(
    parameter int REFRESH_CYCLES = 50000
) (
    input  logic   clk,
    input  logic   reset,
    input  digit_t digit,
    input  logic   valid_key,
    output seg_t   seg,
    output anode_t anode
);

    localparam int REFRESH_W = $clog2(REFRESH_CYCLES + 1);

    digit_t               right_val;
    digit_t               left_val;
    logic                 right_loaded;
    logic                 left_loaded;
    logic [REFRESH_W-1:0] refresh_cnt;
    logic                 sel_left;
    digit_t               shown_val;
    logic                 shown_blank;

    // key history, newest on the right
    always_ff @(posedge clk) begin
        if (valid_key) begin
            right_val <= digit;
            left_val  <= right_val;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            right_loaded <= 1'b0;
            left_loaded  <= 1'b0;
        end else if (valid_key) begin
            right_loaded <= 1'b1;
            left_loaded  <= right_loaded;
        end
    end

    // dwell timer, right digit first
    always_ff @(posedge clk) begin
        if (reset) begin
            refresh_cnt <= '0;
            sel_left    <= 1'b0;
        end else if (refresh_cnt == REFRESH_W'(REFRESH_CYCLES - 1)) begin
            refresh_cnt <= '0;
            sel_left    <= ~sel_left;
        end else begin
            refresh_cnt <= refresh_cnt + 1'b1;
        end
    end

    // active low, only one digit enabled
    assign anode = sel_left ? 2'b01 : 2'b10;

    assign shown_val   = sel_left ? left_val : right_val;
    assign shown_blank = sel_left ? !left_loaded : !right_loaded;

    sevenseg_decoder u_sevenseg (
        .value (shown_val),
        .blank (shown_blank),
        .seg   (seg)
    );

endmodule

`default_nettype wire

// File: keypad_top.sv
// keypad top level: scan FSM and seven-segment display path
`timescale 1ns/1ns
`default_nettype none

module keypad_top import keypad_pkg::*; #(
    parameter int DEBOUNCE_CYCLES = 500000,
    parameter int REFRESH_CYCLES  = 50000
) (
    input  logic   clk,
    input  logic   reset,
    input  scan_t  row,
    output scan_t  col,
    output digit_t digit,
    output logic   valid_key,
    output seg_t   seg,
    output anode_t anode
);

    digit_t key_digit;
    logic   key_valid;

    keypad_fsm #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_fsm (
        .clk       (clk),
        .reset     (reset),
        .row       (row),
        .col       (col),
        .digit     (key_digit),
        .valid_key (key_valid)
    );

    // scanner output also goes straight to the pins
    display_mux #(
        .REFRESH_CYCLES (REFRESH_CYCLES)
    ) u_display (
        .clk       (clk),
        .reset     (reset),
        .digit     (key_digit),
        .valid_key (key_valid),
        .seg       (seg),
        .anode     (anode)
    );

    assign digit     = key_digit;
    assign valid_key = key_valid;

endmodule

`default_nettype wire

// File: tb_clock.sv
// testbench clock and reset generator
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release 1 ns after the edge, like all other stimulus
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: tb_keypad.sv
// keypad testbench: keypad model, stimulus, output monitor and checks
`timescale 1ns/1ns
`default_nettype none

module tb_keypad import keypad_pkg::*; ();

    localparam int DEBOUNCE_CYCLES = 20;
    localparam int REFRESH_CYCLES  = 8;
    localparam int LATENCY_MAX     = DEBOUNCE_CYCLES + 4 * SETTLE_CYCLES + 4;
    localparam int RELEASE_GAP     = 2 * DEBOUNCE_CYCLES + 4 * SETTLE_CYCLES;
    localparam logic [31:0] SEED   = 32'h114303b9;
    // key value per index row * 4 + col, index 0 in the low nibble
    localparam logic [63:0] KEY_MAP = 64'hDF0E_C987_B654_A321;

    logic   clk;
    logic   reset;
    scan_t  row;
    scan_t  col;
    digit_t digit;
    logic   valid_key;
    seg_t   seg;
    anode_t anode;

    int     key_index = 0;
    logic   key_pressed = 1'b0;
    int     pulse_count = 0;
    logic   valid_prev = 1'b0;
    digit_t last_digit = '0;
    digit_t exp_newest = '0;
    digit_t exp_previous = '0;
    string  test_name = "reset";
    int     order [16];
    int     seed_value;
    int     bounce_len;
    int     start_count;
    int     key;

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    keypad_top #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
        .REFRESH_CYCLES  (REFRESH_CYCLES)
    ) DUT (
        .clk       (clk),
        .reset     (reset),
        .row       (row),
        .col       (col),
        .digit     (digit),
        .valid_key (valid_key),
        .seg       (seg),
        .anode     (anode)
    );

    // keypad model, the pressed row follows its column
    assign row = (key_pressed && col == scan_t'(1 << (key_index % 4))) ?
                 scan_t'(1 << (key_index / 4)) : '0;

    function automatic logic is_one_hot(input scan_t v);
        return (v != 4'd0) && ((v & (v - 4'd1)) == 4'd0);
    endfunction

    // gfedcba, active low
    function automatic seg_t font(input digit_t v);
        case (v)
            4'h0: return 7'h40;
            4'h1: return 7'h79;
            4'h2: return 7'h24;
            4'h3: return 7'h30;
            4'h4: return 7'h19;
            4'h5: return 7'h12;
            4'h6: return 7'h02;
            4'h7: return 7'h78;
            4'h8: return 7'h00;
            4'h9: return 7'h10;
            4'hA: return 7'h08;
            4'hB: return 7'h03;
            4'hC: return 7'h46;
            4'hD: return 7'h21;
            4'hE: return 7'h06;
            default: return 7'h0E;
        endcase
    endfunction

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("** Error %s: %s expected %0h, actual %0h",
                     test_name, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // outputs checked on every falling edge once out of reset
    always @(negedge clk) begin
        if (!reset) begin
            assert (is_one_hot(col)) else begin
                $display("col is not one-hot: %b", col);
                abort_run();
            end
            assert (anode == 2'b10 || anode == 2'b01) else begin
                $display("anode does not enable exactly one digit: %b", anode);
                abort_run();
            end
            assert (!(valid_key && valid_prev)) else begin
                $display("valid_key stayed high for more than one cycle");
                abort_run();
            end
            if (valid_key) begin
                pulse_count++;
                last_digit = digit;
            end
            valid_prev = valid_key;
        end
    end

    // a pulse in the n-th cycle after the press is seen after n + 1 steps
    task automatic press_and_expect(input int idx, input int hold_cycles);
        int start;
        int waited;
        start = pulse_count;
        key_index = idx;
        key_pressed = 1'b1;
        waited = 0;
        while (pulse_count == start && waited <= LATENCY_MAX) begin
            next_cycle();
            waited++;
        end
        assert (pulse_count != start) else begin
            $display("no valid_key within %0d cycles after pressing key %0d", LATENCY_MAX, idx);
            abort_run();
        end
        assert (waited > DEBOUNCE_CYCLES) else begin
            $display("valid_key came after %0d cycles, before the debounce time", waited - 1);
            abort_run();
        end
        check_value("digit", KEY_MAP[idx*4 +: 4], last_digit);
        repeat (hold_cycles) next_cycle();
        key_pressed = 1'b0;
        repeat (RELEASE_GAP) next_cycle();
        check_value("pulse count", start + 1, pulse_count);
        exp_previous = exp_newest;
        exp_newest = KEY_MAP[idx*4 +: 4];
    endtask

    // blank digits when both flags are zero
    task automatic check_display(input logic both_blank);
        anode_t last_anode;
        int     run;
        int     changes;
        seg_t   expected;
        last_anode = anode;
        run = 0;
        changes = 0;
        for (int i = 0; i < 6 * REFRESH_CYCLES; i++) begin
            next_cycle();
            if (anode != last_anode) begin
                // first run may be cut short by the start of the loop
                if (changes > 0) begin
                    check_value("dwell", REFRESH_CYCLES, run);
                end
                changes++;
                run = 0;
            end
            run++;
            last_anode = anode;
            if (both_blank) begin
                expected = 7'h7F;
            end else begin
                expected = (anode == 2'b10) ? font(exp_newest) : font(exp_previous);
            end
            check_value(anode == 2'b10 ? "right seg" : "left seg", expected, seg);
        end
        assert (changes >= 2) else begin
            $display("anode did not alternate between the digits");
            abort_run();
        end
    endtask

    initial begin
        int waited;
        seed_value = $urandom(SEED);
        waited = 0;
        while (reset && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        assert (!reset) else begin
            $display("reset was never released");
            abort_run();
        end
        next_cycle();
        check_value("valid_key", 0, valid_key);
        check_value("col", 4'b0001, col);
        check_value("anode", 2'b10, anode);
        check_display(1'b1);

        test_name = "all keys";
        for (int i = 0; i < 16; i++) begin
            order[i] = i;
        end
        for (int i = 15; i > 0; i--) begin
            int j;
            int tmp;
            j = $urandom % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 16; i++) begin
            press_and_expect(order[i], 4);
        end

        test_name = "display";
        check_display(1'b0);

        test_name = "bounce";
        start_count = pulse_count;
        repeat (6) begin
            key_index = $urandom % 16;
            key_pressed = 1'b1;
            bounce_len = 1 + $urandom % (DEBOUNCE_CYCLES - 4);
            repeat (bounce_len) next_cycle();
            key_pressed = 1'b0;
            repeat (1 + $urandom % 3) next_cycle();
        end
        repeat (RELEASE_GAP) next_cycle();
        check_value("pulse count", start_count, pulse_count);

        test_name = "long hold";
        key = $urandom % 16;
        press_and_expect(key, 6 * DEBOUNCE_CYCLES);
        press_and_expect(key, DEBOUNCE_CYCLES);

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
keypad_pkg.sv
keypad_decoder.sv
debouncer.sv
keypad_fsm.sv
sevenseg_decoder.sv
display_mux.sv
keypad_top.sv
tb_clock.sv
tb_keypad.sv

// File: Bender.yml
package:
  name: keypad_scanner

sources:
  - keypad_pkg.sv
  - keypad_decoder.sv
  - debouncer.sv
  - keypad_fsm.sv
  - sevenseg_decoder.sv
  - display_mux.sv
  - keypad_top.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_keypad.sv
